/* Makefile */
TOP := game_screen_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q '^Result: PASSED$$'

clean:
	rm -rf obj_dir

/* logic/draw_pkg.sv */
package draw_pkg;

    // Display size in pixels
    localparam int SCREEN_W = 160;
    localparam int SCREEN_H = 120;

    // Edge of every sprite
    localparam int SPRITE_SIZE = 10;

    // Pixel coordinate, x and y share the width
    typedef logic [7:0] coord_t;

    // One bit each for red, green, blue
    typedef logic [2:0] colour_t;

    localparam colour_t COL_BLACK  = 3'd0;
    localparam colour_t COL_RED    = 3'd4; // Player
    localparam colour_t COL_YELLOW = 3'd6; // Blocks
    localparam colour_t COL_WHITE  = 3'd7; // Spikes

endpackage

/* logic/frame_timer.sv */
`timescale 1ns/1ps

module frame_timer #(
    parameter int FRAME_CYCLES = 833333
) (
    input  logic clock_50,
    input  logic arst_n,
    output logic frame_tick
);

    localparam int CW = $clog2(FRAME_CYCLES);

    logic [CW-1:0] count;

    // One tick per period, then the count starts over
    always_ff @(posedge clock_50 or negedge arst_n) begin
        if (!arst_n) begin
            count      <= '0;
            frame_tick <= 1'b0;
        end else begin
            frame_tick <= 1'b0;
            if (count == CW'(FRAME_CYCLES - 1)) begin
                count      <= '0;
                frame_tick <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

/* logic/game_screen.sv */
`timescale 1ns/1ps

module game_screen #(
    parameter int FRAME_CYCLES = 833333
) (
    input  logic              clock_50,
    input  logic              arst_n,
    input  logic              start,
    input  draw_pkg::coord_t  player_y,
    output logic              plot,
    output draw_pkg::coord_t  plot_x,
    output draw_pkg::coord_t  plot_y,
    output draw_pkg::colour_t plot_colour,
    output logic              frame_done
);

    logic               frame_tick;
    // Clearer
    logic               clear_start;
    logic               clear_done;
    logic               clear_plot;
    draw_pkg::coord_t   clear_x;
    draw_pkg::coord_t   clear_y;
    draw_pkg::colour_t  clear_colour;
    // Painter
    logic               paint_start;
    logic               paint_done;
    scene_pkg::sprite_t sprite;
    draw_pkg::colour_t  colour;
    draw_pkg::coord_t   corner_x;
    draw_pkg::coord_t   corner_y;
    logic               paint_plot;
    draw_pkg::coord_t   paint_x;
    draw_pkg::coord_t   paint_y;
    draw_pkg::colour_t  paint_colour;

    frame_timer #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) timer0 (
        .clock_50   (clock_50),
        .arst_n     (arst_n),
        .frame_tick (frame_tick)
    );

    plot_sequencer seq0 (
        .clock_50     (clock_50),
        .arst_n       (arst_n),
        .start        (start),
        .frame_tick   (frame_tick),
        .player_y     (player_y),
        .clear_start  (clear_start),
        .clear_done   (clear_done),
        .clear_plot   (clear_plot),
        .clear_x      (clear_x),
        .clear_y      (clear_y),
        .clear_colour (clear_colour),
        .paint_start  (paint_start),
        .sprite       (sprite),
        .colour       (colour),
        .corner_x     (corner_x),
        .corner_y     (corner_y),
        .paint_done   (paint_done),
        .paint_plot   (paint_plot),
        .paint_x      (paint_x),
        .paint_y      (paint_y),
        .paint_colour (paint_colour),
        .plot         (plot),
        .plot_x       (plot_x),
        .plot_y       (plot_y),
        .plot_colour  (plot_colour),
        .frame_done   (frame_done)
    );

    screen_clearer clearer0 (
        .clock_50    (clock_50),
        .arst_n      (arst_n),
        .clear_start (clear_start),
        .plot        (clear_plot),
        .plot_x      (clear_x),
        .plot_y      (clear_y),
        .plot_colour (clear_colour),
        .clear_done  (clear_done)
    );

    sprite_painter painter0 (
        .clock_50    (clock_50),
        .arst_n      (arst_n),
        .paint_start (paint_start),
        .sprite      (sprite),
        .colour      (colour),
        .corner_x    (corner_x),
        .corner_y    (corner_y),
        .plot        (paint_plot),
        .plot_x      (paint_x),
        .plot_y      (paint_y),
        .plot_colour (paint_colour),
        .paint_done  (paint_done)
    );

endmodule

/* logic/plot_sequencer.sv */
`timescale 1ns/1ps

module plot_sequencer (
    input  logic               clock_50,
    input  logic               arst_n,
    input  logic               start,
    input  logic               frame_tick,
    input  draw_pkg::coord_t   player_y,
    // Clearer side
    output logic               clear_start,
    input  logic               clear_done,
    input  logic               clear_plot,
    input  draw_pkg::coord_t   clear_x,
    input  draw_pkg::coord_t   clear_y,
    input  draw_pkg::colour_t  clear_colour,
    // Painter side
    output logic               paint_start,
    output scene_pkg::sprite_t sprite,
    output draw_pkg::colour_t  colour,
    output draw_pkg::coord_t   corner_x,
    output draw_pkg::coord_t   corner_y,
    input  logic               paint_done,
    input  logic               paint_plot,
    input  draw_pkg::coord_t   paint_x,
    input  draw_pkg::coord_t   paint_y,
    input  draw_pkg::colour_t  paint_colour,
    // Shared plot bus
    output logic               plot,
    output draw_pkg::coord_t   plot_x,
    output draw_pkg::coord_t   plot_y,
    output draw_pkg::colour_t  plot_colour,
    output logic               frame_done
);

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        PAINT,
        DONE
    } state_t;

    state_t                state;
    scene_pkg::obj_idx_t   obj;
    draw_pkg::coord_t      player_y_lat;
    logic                  last_obj;

    assign last_obj = (obj == scene_pkg::obj_idx_t'(scene_pkg::NUM_OBJECTS - 1));

    always_ff @(posedge clock_50 or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            obj         <= '0;
            clear_start <= 1'b0;
            paint_start <= 1'b0;
        end else begin
            clear_start <= 1'b0;
            paint_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (frame_tick && start) begin // Ticks are dropped otherwise
                        state       <= CLEAR;
                        obj         <= '0;
                        clear_start <= 1'b1;
                    end
                end
                CLEAR: begin
                    if (clear_done) begin
                        state       <= PAINT;
                        paint_start <= 1'b1;
                    end
                end
                PAINT: begin
                    if (paint_done) begin
                        if (last_obj) begin
                            state <= DONE;
                        end else begin
                            obj         <= obj + 1'b1;
                            paint_start <= 1'b1; // Next object straight away
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Player height is fixed for the whole frame
    always_ff @(posedge clock_50) begin
        if (state == IDLE && frame_tick && start) begin
            player_y_lat <= player_y;
        end
    end

    // Current object entry, steady while the painter scans
    assign sprite   = scene_pkg::OBJ_SPRITE[obj];
    assign colour   = scene_pkg::OBJ_COLOUR[obj];
    assign corner_x = scene_pkg::OBJ_X[obj];
    assign corner_y = (obj == '0) ? player_y_lat : scene_pkg::OBJ_Y[obj];

    // Bus grant follows the state
    always_comb begin
        plot        = 1'b0;
        plot_x      = '0;
        plot_y      = '0;
        plot_colour = draw_pkg::COL_BLACK;
        case (state)
            CLEAR: begin
                plot        = clear_plot;
                plot_x      = clear_x;
                plot_y      = clear_y;
                plot_colour = clear_colour;
            end
            PAINT: begin
                plot        = paint_plot;
                plot_x      = paint_x;
                plot_y      = paint_y;
                plot_colour = paint_colour;
            end
            default: ;
        endcase
    end

    assign frame_done = (state == DONE);

endmodule

/* logic/scene_pkg.sv */
package scene_pkg;

    typedef enum logic {
        SPR_SQUARE,
        SPR_SPIKE
    } sprite_t;

    // Row or column inside a sprite, 0 to 9
    typedef logic [3:0] span_t;

    localparam int NUM_OBJECTS = 8;

    typedef logic [2:0] obj_idx_t;

    // First and last filled column per row, row 0 on top
    // Outer index follows sprite_t
    localparam span_t ROW_FIRST [2][10] = '{
        '{4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0},
        '{4'd4, 4'd4, 4'd3, 4'd3, 4'd2, 4'd2, 4'd1, 4'd1, 4'd0, 4'd0}
    };
    localparam span_t ROW_LAST [2][10] = '{
        '{4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9},
        '{4'd5, 4'd5, 4'd6, 4'd6, 4'd7, 4'd7, 4'd8, 4'd8, 4'd9, 4'd9}
    };

    // Fixed scene, drawn in index order
    // Object 0 is the player
    localparam sprite_t OBJ_SPRITE [NUM_OBJECTS] = '{
        SPR_SQUARE, SPR_SQUARE, SPR_SQUARE, SPR_SQUARE,
        SPR_SQUARE, SPR_SQUARE, SPR_SPIKE, SPR_SPIKE
    };
    localparam draw_pkg::colour_t OBJ_COLOUR [NUM_OBJECTS] = '{
        draw_pkg::COL_RED,    draw_pkg::COL_YELLOW, draw_pkg::COL_YELLOW,
        draw_pkg::COL_YELLOW, draw_pkg::COL_YELLOW, draw_pkg::COL_YELLOW,
        draw_pkg::COL_WHITE,  draw_pkg::COL_WHITE
    };

    // Bottom-left corners
    localparam draw_pkg::coord_t OBJ_X [NUM_OBJECTS] = '{
        8'd59, 8'd69, 8'd99, 8'd109, 8'd119, 8'd129, 8'd139, 8'd149
    };
    localparam draw_pkg::coord_t OBJ_Y [NUM_OBJECTS] = '{
        8'd0,  // Player height comes from the input
        8'd89, 8'd59, 8'd39, 8'd59, 8'd89, 8'd89, 8'd59
    };

endpackage

/* logic/screen_clearer.sv */
`timescale 1ns/1ps

module screen_clearer (
    input  logic              clock_50,
    input  logic              arst_n,
    input  logic              clear_start,
    output logic              plot,
    output draw_pkg::coord_t  plot_x,
    output draw_pkg::coord_t  plot_y,
    output draw_pkg::colour_t plot_colour,
    output logic              clear_done
);

    logic             busy;
    draw_pkg::coord_t x;
    draw_pkg::coord_t y;
    logic             x_last;
    logic             y_last;

    assign x_last = (x == draw_pkg::coord_t'(draw_pkg::SCREEN_W - 1));
    assign y_last = (y == draw_pkg::coord_t'(draw_pkg::SCREEN_H - 1));

    // Raster scan, x fastest
    always_ff @(posedge clock_50 or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            x    <= '0;
            y    <= '0;
        end else if (clear_start) begin
            busy <= 1'b1;
            x    <= '0;
            y    <= '0;
        end else if (busy) begin
            if (x_last) begin
                x <= '0;
                y <= y + 1'b1;
                if (y_last) begin
                    busy <= 1'b0; // Whole screen covered
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    assign plot        = busy;
    assign plot_x      = x;
    assign plot_y      = y;
    assign plot_colour = draw_pkg::COL_BLACK;
    assign clear_done  = busy && x_last && y_last; // With the final pixel

endmodule

/* logic/sprite_painter.sv */
`timescale 1ns/1ps

module sprite_painter (
    input  logic              clock_50,
    input  logic              arst_n,
    input  logic              paint_start,
    input  scene_pkg::sprite_t sprite,
    input  draw_pkg::colour_t colour,
    input  draw_pkg::coord_t  corner_x,
    input  draw_pkg::coord_t  corner_y,
    output logic              plot,
    output draw_pkg::coord_t  plot_x,
    output draw_pkg::coord_t  plot_y,
    output draw_pkg::colour_t plot_colour,
    output logic              paint_done
);

    localparam scene_pkg::span_t LAST_POS = scene_pkg::span_t'(draw_pkg::SPRITE_SIZE - 1);

    logic             busy;
    scene_pkg::span_t row;
    scene_pkg::span_t col;
    scene_pkg::span_t span_first;
    scene_pkg::span_t span_last;
    logic             in_span;
    logic             row_last;
    logic             col_last;

    assign row_last = (row == LAST_POS);
    assign col_last = (col == LAST_POS);

    // Scan all 100 positions, columns fastest
    always_ff @(posedge clock_50 or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            row  <= '0;
            col  <= '0;
        end else if (paint_start) begin
            busy <= 1'b1;
            row  <= '0;
            col  <= '0;
        end else if (busy) begin
            if (col_last) begin
                col <= '0;
                row <= row + 1'b1;
                if (row_last) begin
                    busy <= 1'b0;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Shape of the current row
    assign span_first = scene_pkg::ROW_FIRST[sprite][row];
    assign span_last  = scene_pkg::ROW_LAST[sprite][row];
    assign in_span    = (col >= span_first) && (col <= span_last);

    assign plot        = busy && in_span;
    assign plot_x      = corner_x + draw_pkg::coord_t'(col);
    // Corner is the bottom row, so row 0 sits SPRITE_SIZE-1 above it
    assign plot_y      = corner_y - draw_pkg::coord_t'(LAST_POS) + draw_pkg::coord_t'(row);
    assign plot_colour = colour;
    assign paint_done  = busy && row_last && col_last; // Last scan position

endmodule

/* verification/game_screen_tb.sv */
`timescale 1ns/1ps

module game_screen_tb;

    localparam int FRAME_CYCLES   = 25000;
    localparam int NUM_FRAMES     = 6;
    localparam int IDLE_PERIODS   = 3;
    localparam int W              = draw_pkg::SCREEN_W;
    localparam int H              = draw_pkg::SCREEN_H;
    localparam int CLEAR_PIXELS   = W * H;
    localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES + 2000; // Counted from the first start
    localparam int MAX_PRINTS     = 10;

    // Scene by bottom-left corner, object 0 is the player
    localparam int SCENE_X [8] = '{59, 69, 99, 109, 119, 129, 139, 149};
    localparam int SCENE_Y [8] = '{0, 89, 59, 39, 59, 89, 89, 59};
    localparam bit SCENE_SPIKE [8] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    localparam draw_pkg::colour_t SCENE_COLOUR [8] = '{
        draw_pkg::COL_RED,    draw_pkg::COL_YELLOW, draw_pkg::COL_YELLOW,
        draw_pkg::COL_YELLOW, draw_pkg::COL_YELLOW, draw_pkg::COL_YELLOW,
        draw_pkg::COL_WHITE,  draw_pkg::COL_WHITE
    };

    logic              clock_50;
    logic              arst_n;
    logic              start;
    draw_pkg::coord_t  player_y;
    logic              plot;
    draw_pkg::coord_t  plot_x;
    draw_pkg::coord_t  plot_y;
    draw_pkg::colour_t plot_colour;
    logic              frame_done;

    draw_pkg::colour_t fb      [W][H]; // Written on every plot
    draw_pkg::colour_t exp_img [W][H];

    logic [31:0] rng_state;
    int          cur_py;
    int          plot_count    = 0;
    int          frames_seen   = 0;
    int          run_cycles    = 0;
    bit          quiet         = 1'b1; // Bus must stay silent
    bit          armed         = 1'b0;
    int          raster_errors = 0;
    int          count_errors  = 0;
    int          image_errors  = 0;
    int          quiet_errors  = 0;
    int          run_errors    = 0;
    int          bus_errors    = 0;

    game_screen #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) dut0 (
        .clock_50    (clock_50),
        .arst_n      (arst_n),
        .start       (start),
        .player_y    (player_y),
        .plot        (plot),
        .plot_x      (plot_x),
        .plot_y      (plot_y),
        .plot_colour (plot_colour),
        .frame_done  (frame_done)
    );

    bind game_screen plot_bus_chk chk0 (
        .clock_50   (clock_50),
        .arst_n     (arst_n),
        .plot       (plot),
        .plot_x     (plot_x),
        .plot_y     (plot_y),
        .frame_done (frame_done)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic bit in_span(input bit spike, input int row, input int col);
        int half;
        half = row / 2;
        if (!spike) begin
            return 1'b1;
        end
        return (col >= 4 - half) && (col <= 5 + half); // One column wider every two rows
    endfunction

    function automatic int scene_pixels();
        int n;
        n = 0;
        for (int o = 0; o < 8; o++)
            for (int r = 0; r < 10; r++)
                for (int c = 0; c < 10; c++)
                    if (in_span(SCENE_SPIKE[o], r, c)) n++;
        return n;
    endfunction

    // Black screen, then the objects in index order
    task automatic check_image(input int py);
        int oy;
        for (int x = 0; x < W; x++)
            for (int y = 0; y < H; y++)
                exp_img[x][y] = draw_pkg::COL_BLACK;
        for (int o = 0; o < 8; o++) begin
            oy = (o == 0) ? py : SCENE_Y[o];
            for (int r = 0; r < 10; r++)
                for (int c = 0; c < 10; c++)
                    if (in_span(SCENE_SPIKE[o], r, c))
                        exp_img[SCENE_X[o] + c][oy - 9 + r] = SCENE_COLOUR[o];
        end
        for (int x = 0; x < W; x++) begin
            for (int y = 0; y < H; y++) begin
                assert (fb[x][y] === exp_img[x][y]) else begin
                    image_errors++;
                    if (image_errors <= MAX_PRINTS)
                        $display("Mismatch plot_colour at x %0d y %0d: got %h, expected %h",
                                 x, y, fb[x][y], exp_img[x][y]);
                end
            end
        end
    endtask

    task automatic report_counts();
        bus_errors = dut0.chk0.range_fails + dut0.chk0.double_fails + dut0.chk0.overlap_fails;
        $display("Errors: raster %0d, plot count %0d, image %0d, idle bus %0d, frames %0d, bus %0d",
                 raster_errors, count_errors, image_errors, quiet_errors, run_errors, bus_errors);
    endtask

    initial begin
        clock_50 = 1'b0;
        forever #5 clock_50 = ~clock_50;
    end

    // Sampled on the falling edge, away from the drive edge
    always @(negedge clock_50) begin
        if (plot) begin
            if (plot_count < CLEAR_PIXELS) begin
                assert (int'(plot_x) == plot_count % W) else begin
                    raster_errors++;
                    $display("Mismatch plot_x at clear step %0d: got %h, expected %h",
                             plot_count, plot_x, draw_pkg::coord_t'(plot_count % W));
                end
                assert (int'(plot_y) == plot_count / W) else begin
                    raster_errors++;
                    $display("Mismatch plot_y at clear step %0d: got %h, expected %h",
                             plot_count, plot_y, draw_pkg::coord_t'(plot_count / W));
                end
                assert (plot_colour == draw_pkg::COL_BLACK) else begin
                    raster_errors++;
                    $display("Mismatch plot_colour at clear step %0d: got %h, expected %h",
                             plot_count, plot_colour, draw_pkg::COL_BLACK);
                end
            end
            if (int'(plot_x) < W && int'(plot_y) < H)
                fb[int'(plot_x)][int'(plot_y)] = plot_colour;
            plot_count++;
        end
        if (frame_done) begin
            assert (plot_count == CLEAR_PIXELS + scene_pixels()) else begin
                count_errors++;
                $display("Mismatch plot count in frame %0d: got %h, expected %h",
                         frames_seen + 1, plot_count, CLEAR_PIXELS + scene_pixels());
            end
            check_image(cur_py);
            frames_seen++;
            plot_count = 0;
            $display("Frame %0d done, player_y %0d", frames_seen, cur_py);
        end
        if (quiet) begin
            assert (!plot && !frame_done) else begin
                quiet_errors++;
                $display("Plot bus active while no frame may run");
            end
        end
    end

    initial begin : watchdog
        wait (armed);
        while (run_cycles < TIMEOUT_CYCLES) begin
            @(posedge clock_50);
            run_cycles++;
        end
        $display("Timeout after %0d cycles with %0d frames done", run_cycles, frames_seen);
        report_counts();
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        arst_n    = 1'b0;
        start     = 1'b0;
        rng_state = 32'd41728;
        rng_state = next_random(rng_state);
        cur_py    = 9 + int'(rng_state % 32'd111);
        player_y  = draw_pkg::coord_t'(cur_py);
        repeat (10) @(posedge clock_50);
        arst_n <= 1'b1;

        // Several ticks go by with start low
        repeat (IDLE_PERIODS * FRAME_CYCLES + FRAME_CYCLES / 2) @(posedge clock_50);
        start <= 1'b1;
        quiet = 1'b0;
        armed = 1'b1;

        for (int f = 1; f <= NUM_FRAMES; f++) begin
            if (f == NUM_FRAMES) begin
                while (plot_count < CLEAR_PIXELS / 2) @(posedge clock_50);
                start <= 1'b0; // Last frame runs on to the end
            end
            while (frames_seen < f) @(posedge clock_50);
            if (f < NUM_FRAMES) begin
                rng_state = next_random(rng_state);
                cur_py    = 9 + int'(rng_state % 32'd111);
                player_y <= draw_pkg::coord_t'(cur_py);
            end
        end

        quiet = 1'b1;
        repeat (FRAME_CYCLES + 1000) @(posedge clock_50);
        assert (frames_seen == NUM_FRAMES) else begin
            run_errors++;
            $display("Mismatch frame count: got %h, expected %h", frames_seen, NUM_FRAMES);
        end

        report_counts();
        if (raster_errors + count_errors + image_errors + quiet_errors + run_errors
            + bus_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verification/plot_bus_chk.sv */
`timescale 1ns/1ps

module plot_bus_chk (
    input logic             clock_50,
    input logic             arst_n,
    input logic             plot,
    input draw_pkg::coord_t plot_x,
    input draw_pkg::coord_t plot_y,
    input logic             frame_done
);

    int range_fails   = 0;
    int double_fails  = 0;
    int overlap_fails = 0;

    // Every plotted pixel lies on the screen
    plot_on_screen: assert property (@(posedge clock_50) disable iff (!arst_n)
        plot |-> (plot_x < draw_pkg::coord_t'(draw_pkg::SCREEN_W)
               && plot_y < draw_pkg::coord_t'(draw_pkg::SCREEN_H)))
        else begin
            range_fails++;
            $error("plot outside the screen at x %h y %h", plot_x, plot_y);
        end

    done_single: assert property (@(posedge clock_50) disable iff (!arst_n)
        frame_done |=> !frame_done)
        else begin
            double_fails++;
            $error("frame_done high on two cycles in a row");
        end

    done_not_plotting: assert property (@(posedge clock_50) disable iff (!arst_n)
        !(frame_done && plot))
        else begin
            overlap_fails++;
            $error("frame_done together with plot");
        end

endmodule

/* verilog.f */
logic/draw_pkg.sv
logic/scene_pkg.sv
logic/frame_timer.sv
logic/screen_clearer.sv
logic/sprite_painter.sv
logic/plot_sequencer.sv
logic/game_screen.sv
verification/plot_bus_chk.sv
verification/game_screen_tb.sv
